// File: hdl/microroc_sc_defs.svh
`ifndef MICROROC_SC_DEFS_SVH
`define MICROROC_SC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// slow control path sizes
////////////////////////////////////////////////////////////////////////////

`define SC_WORD_W   16  // frame word and usb control word
`define DAC_W       10  // threshold dac code
`define HEADER_W    8   // asic header

// word buffer, must stay deeper than one frame
`define FIFO_DEPTH  8
`define FRAME_WORDS 4   // header, dac0, dac1, dac2

`define RST_CYCLES  2   // sr_rstb low time before a frame

`endif

// File: hdl/usb_cmd_pkg.sv
`include "microroc_sc_defs.svh"

// command side of the usb control path
package usb_cmd_pkg;

    // opcode lives in the top nibble of the control word
    typedef enum logic [3:0] {
        OP_DAC0   = 4'd1,
        OP_DAC1   = 4'd2,
        OP_DAC2   = 4'd3,
        OP_HEADER = 4'd4,
        OP_MODE   = 4'd5,
        OP_LOAD   = 4'd6   // frame out to the asic
    } sc_opcode_e;

    typedef struct packed {
        sc_opcode_e                opcode;
        logic [`SC_WORD_W-5:0]     arg;    // 12 bit argument
    } ctrl_word_t;

    // level on the select pin
    typedef enum logic [0:0] {
        MODE_READ = 1'b0,  // read register
        MODE_SC   = 1'b1   // slow control register
    } sc_mode_e;

endpackage

// File: hdl/sc_frame_pkg.sv
`include "microroc_sc_defs.svh"

// frame side, buffer entries and serializer
package sc_frame_pkg;

    typedef logic [`SC_WORD_W-1:0] sc_data_t;  // one serial word

    // first marks the header word of a frame
    typedef struct packed {
        logic     first;
        sc_data_t data;
    } sc_entry_t;

    typedef enum logic [2:0] {
        SH_IDLE,   // waiting for a word
        SH_RESET,  // sr_rstb low before a frame
        SH_LOW,    // sr_ck low, data set up
        SH_HIGH,   // sr_ck high, asic samples
        SH_NEXT    // word done, fetch or finish
    } shift_state_e;

endpackage

// File: hdl/usb_cmd_decoder.sv
`timescale 1ns/1ps
`include "microroc_sc_defs.svh"

module usb_cmd_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ctrl_wr,
    input  usb_cmd_pkg::ctrl_word_t ctrl_word,
    output usb_cmd_pkg::sc_mode_e   mode,
    output logic                    push,
    output sc_frame_pkg::sc_entry_t entry,
    input  logic                    full
);
    import usb_cmd_pkg::*;
    import sc_frame_pkg::*;

    localparam int IDX_W = $clog2(`FRAME_WORDS);

    logic [`DAC_W-1:0]    dac0;      // threshold dacs
    logic [`DAC_W-1:0]    dac1;
    logic [`DAC_W-1:0]    dac2;
    logic [`HEADER_W-1:0] header;
    logic                 loading;   // frame push in progress
    logic [IDX_W-1:0]     word_idx;  // word of the frame being pushed

    ////////////////////////////////////////////////////////////////////////////
    // parameter registers
    ////////////////////////////////////////////////////////////////////////////

    // commands dropped while a frame goes out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dac0   <= '0;
            dac1   <= '0;
            dac2   <= '0;
            header <= '0;
            mode   <= MODE_READ;
        end else if (ctrl_wr && !loading) begin
            case (ctrl_word.opcode)
                OP_DAC0:   dac0   <= ctrl_word.arg[`DAC_W-1:0];
                OP_DAC1:   dac1   <= ctrl_word.arg[`DAC_W-1:0];
                OP_DAC2:   dac2   <= ctrl_word.arg[`DAC_W-1:0];
                OP_HEADER: header <= ctrl_word.arg[`HEADER_W-1:0];
                OP_MODE:   mode   <= sc_mode_e'(ctrl_word.arg[0]);  // bit 0 only
                default: ;  // load and unused codes
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame push
    ////////////////////////////////////////////////////////////////////////////

    assign push = loading && !full;  // stall in place on full

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loading  <= 1'b0;
            word_idx <= '0;
        end else if (!loading) begin
            if (ctrl_wr && ctrl_word.opcode == OP_LOAD) begin
                loading  <= 1'b1;
                word_idx <= '0;
            end
        end else if (push) begin
            if (word_idx == IDX_W'(`FRAME_WORDS - 1))
                loading <= 1'b0;  // last word accepted
            word_idx <= word_idx + 1'b1;
        end
    end

    // header, dac0, dac1, dac2, zero extended
    always_comb begin
        entry.first = (word_idx == '0);
        case (word_idx)
            IDX_W'(0): entry.data = sc_data_t'(header);
            IDX_W'(1): entry.data = sc_data_t'(dac0);
            IDX_W'(2): entry.data = sc_data_t'(dac1);
            default:   entry.data = sc_data_t'(dac2);
        endcase
    end

endmodule

// File: hdl/sc_word_fifo.sv
`timescale 1ns/1ps
`include "microroc_sc_defs.svh"

module sc_word_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  sc_frame_pkg::sc_entry_t wr_entry,
    output logic                    full,
    input  logic                    pop,
    output sc_frame_pkg::sc_entry_t rd_entry,
    output logic                    empty
);
    import sc_frame_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    sc_entry_t        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // one extra bit for full
    logic             do_pop;  // pop guarded against empty

    assign empty    = (count == '0);
    assign full     = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign do_pop   = pop && !empty;
    assign rd_entry = mem[rd_ptr];  // head falls through

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_entry;
    end

    // pointers wrap on the power of two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither
            endcase
        end
    end

endmodule

// File: hdl/sc_shift_ctrl.sv
`timescale 1ns/1ps
`include "microroc_sc_defs.svh"

module sc_shift_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    pop,
    input  sc_frame_pkg::sc_entry_t rd_entry,
    input  logic                    empty,
    output logic                    sr_rstb,
    output logic                    sr_ck,
    output logic                    sr_in,
    output logic                    config_done
);
    import sc_frame_pkg::*;

    localparam int BIT_W = $clog2(`SC_WORD_W);
    localparam int RST_W = $clog2(`RST_CYCLES + 1);

    shift_state_e     state;
    sc_data_t         shreg;      // msb goes out first
    logic [BIT_W-1:0] bit_cnt;    // bits left after this one
    logic [RST_W-1:0] rst_cnt;
    logic             frame_end;  // nothing more for this frame

    // a header word seen in SH_NEXT starts a new frame from idle
    assign pop = !empty && ((state == SH_IDLE) ||
                            (state == SH_NEXT && !rd_entry.first));
    assign frame_end = (state == SH_NEXT) && !pop;

    ////////////////////////////////////////////////////////////////////////////
    // serializer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SH_IDLE;
            bit_cnt     <= '0;
            rst_cnt     <= '0;
            config_done <= 1'b0;
        end else begin
            config_done <= frame_end;  // single cycle
            case (state)
                SH_IDLE, SH_NEXT: begin
                    if (pop) begin
                        bit_cnt <= BIT_W'(`SC_WORD_W - 1);
                        if (rd_entry.first) begin
                            rst_cnt <= RST_W'(`RST_CYCLES - 1);
                            state   <= SH_RESET;
                        end else begin
                            state <= SH_LOW;
                        end
                    end else begin
                        state <= SH_IDLE;
                    end
                end
                SH_RESET: begin
                    if (rst_cnt == '0)
                        state <= SH_LOW;
                    else
                        rst_cnt <= rst_cnt - 1'b1;
                end
                SH_LOW:  state <= SH_HIGH;  // setup half
                SH_HIGH: begin
                    if (bit_cnt == '0) begin
                        state <= SH_NEXT;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                        state   <= SH_LOW;
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            shreg <= rd_entry.data;
        else if (state == SH_HIGH && bit_cnt != '0)
            shreg <= shreg << 1;  // next bit after the rising edge
    end

    // pins decoded from state, idle levels ck=0 in=0 rstb=1
    assign sr_ck   = (state == SH_HIGH);
    assign sr_rstb = (state != SH_RESET);
    assign sr_in   = ((state == SH_LOW) || (state == SH_HIGH)) && shreg[`SC_WORD_W-1];

endmodule

// File: hdl/microroc_sc_top.sv
`timescale 1ns/1ps
`include "microroc_sc_defs.svh"

module microroc_sc_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ctrl_wr,      // one cycle strobe from usb
    input  logic [`SC_WORD_W-1:0] ctrl_word,
    output logic                  select,       // 1 slow control, 0 read register
    output logic                  sr_rstb,      // selected register reset
    output logic                  sr_ck,        // selected register clock
    output logic                  sr_in,        // selected register data
    output logic                  config_done
);
    import usb_cmd_pkg::*;
    import sc_frame_pkg::*;

    sc_mode_e  mode;
    logic      push;
    logic      pop;
    logic      full;
    logic      empty;
    sc_entry_t wr_entry;  // decoder to buffer
    sc_entry_t rd_entry;  // buffer head to shifter

    usb_cmd_decoder decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_wr   (ctrl_wr),
        .ctrl_word (ctrl_word),  // packed into opcode and argument
        .mode      (mode),
        .push      (push),
        .entry     (wr_entry),
        .full      (full)
    );

    sc_word_fifo fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .wr_entry (wr_entry),
        .full     (full),
        .pop      (pop),
        .rd_entry (rd_entry),
        .empty    (empty)
    );

    sc_shift_ctrl shifter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop         (pop),
        .rd_entry    (rd_entry),
        .empty       (empty),
        .sr_rstb     (sr_rstb),
        .sr_ck       (sr_ck),
        .sr_in       (sr_in),
        .config_done (config_done)
    );

    assign select = mode;  // enum level straight to the pin

endmodule

// File: dv/microroc_sc_properties.sv
`timescale 1ns/1ps

module microroc_sc_properties (
    input logic clk,
    input logic rst_n,
    input logic sr_rstb,
    input logic sr_ck,
    input logic sr_in,
    input logic config_done
);

    // data held through the asic rising edge
    sr_in_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        sr_ck |-> $stable(sr_in))
        else $error("sr_in changed while sr_ck was high");

    config_done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        config_done |=> !config_done)  // end of frame flag
        else $error("config_done held for more than one cycle");

    // shift clock stays low through the register reset and one cycle after
    rstb_ck_overlap_a: assert property (@(posedge clk) disable iff (!rst_n)
        !sr_rstb |-> !sr_ck ##1 !sr_ck)
        else $error("sr_ck high during or right after sr_rstb low");

endmodule

bind sc_shift_ctrl microroc_sc_properties props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sr_rstb     (sr_rstb),
    .sr_ck       (sr_ck),
    .sr_in       (sr_in),
    .config_done (config_done)
);

// File: dv/tb_microroc_sc.sv
`timescale 1ns/1ps
`include "microroc_sc_defs.svh"

module tb_microroc_sc;
    import usb_cmd_pkg::*;
    import sc_frame_pkg::*;

    localparam int DONE_TIMEOUT = 2000;  // cycles per frame

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  ctrl_wr;
    logic [`SC_WORD_W-1:0] ctrl_word;
    logic                  select;
    logic                  sr_rstb;
    logic                  sr_ck;
    logic                  sr_in;
    logic                  config_done;

    sc_data_t exp_q[$];                  // expected frame words from the file
    sc_data_t got_q[$];                  // words rebuilt from sr_in
    sc_data_t shift_word    = '0;
    int       frame_bits    = 0;         // bits seen since last done
    int       rst_lows      = 0;         // sr_rstb low cycles before first bit
    logic     ck_prev       = 1'b0;
    sc_mode_e exp_mode      = MODE_READ;
    bit       frame_pending = 1'b0;      // load sent but frame not checked yet

    microroc_sc_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl_wr     (ctrl_wr),
        .ctrl_word   (ctrl_word),
        .select      (select),
        .sr_rstb     (sr_rstb),
        .sr_ck       (sr_ck),
        .sr_in       (sr_in),
        .config_done (config_done)
    );

    always #50 clk = ~clk;  // 100 ns period

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_stop();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        fail_stop();
    endtask

    task automatic check_word(input string name, input sc_data_t got, input sc_data_t want);
        if (got !== want) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, want);
            fail_stop();
        end
    endtask

    task automatic check_mode(input string name, input sc_mode_e got, input sc_mode_e want);
        if (got !== want) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, want);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, want);
            fail_stop();
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, want);
            fail_stop();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // serial capture sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (!sr_rstb) begin
                if (frame_bits != 0)
                    report_error("sr_rstb went low inside a frame");
                rst_lows = rst_lows + 1;
            end
            if (sr_ck && !ck_prev) begin  // asic samples here
                if (frame_bits == 0)
                    check_count("sr_rstb low cycles", rst_lows, `RST_CYCLES);
                shift_word = {shift_word[`SC_WORD_W-2:0], sr_in};  // msb first
                frame_bits = frame_bits + 1;
                if (frame_bits % `SC_WORD_W == 0)
                    got_q.push_back(shift_word);
            end
            if (config_done) begin
                frame_bits = 0;
                rst_lows   = 0;
            end
            ck_prev = sr_ck;
        end
    end

    // one strobe on the falling edge with select checked a cycle later
    task automatic send_cmd(input logic [`SC_WORD_W-1:0] word);
        ctrl_word_t cmd;
        cmd       = ctrl_word_t'(word);
        ctrl_wr   = 1'b1;
        ctrl_word = word;
        @(negedge clk);
        ctrl_wr   = 1'b0;
        ctrl_word = '0;
        if (cmd.opcode == OP_MODE)
            exp_mode = cmd.arg[0] ? MODE_SC : MODE_READ;
        if (cmd.opcode == OP_LOAD)
            frame_pending = 1'b1;
        check_mode("select", sc_mode_e'(select), exp_mode);
    endtask

    task automatic wait_frame();
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            seen   = config_done;
            cycles = cycles + 1;
        end
        if (!seen)
            report_error("config_done did not arrive within 2000 cycles");
        check_count("frame words", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++)
            check_word($sformatf("sr_in word %0d", i), got_q[i], exp_q[i]);
        got_q.delete();
        exp_q.delete();
        frame_pending = 1'b0;
        @(negedge clk);
        check_bit("config_done", config_done, 1'b0);  // single pulse
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus from the data file
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int                    fd;
        int                    n;
        string                 line;
        logic [7:0]            kind;
        logic [`SC_WORD_W-1:0] value;

        rst_n     = 1'b0;
        ctrl_wr   = 1'b0;
        ctrl_word = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("sr_ck", sr_ck, 1'b0);  // idle pin levels
        check_bit("sr_in", sr_in, 1'b0);
        check_bit("sr_rstb", sr_rstb, 1'b1);
        check_bit("config_done", config_done, 1'b0);
        check_mode("select", sc_mode_e'(select), MODE_READ);

        fd = $fopen("dv/sc_input.txt", "r");
        if (fd == 0)
            report_error("could not open dv/sc_input.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h", kind, value);
                if (n != 2) begin
                    report_error({"cannot parse stimulus line ", line});
                end else if (kind == "C") begin
                    if (frame_pending)
                        wait_frame();  // previous load first
                    send_cmd(value);
                end else if (kind == "E") begin
                    exp_q.push_back(value);
                end else begin
                    report_error({"unknown line kind in ", line});
                end
            end
        end
        $fclose(fd);
        if (frame_pending)
            wait_frame();

        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_error("expected frame words left over without a load");
        end
    end

endmodule

// File: dv/sc_input.txt
# C hhhh drives one control word, opcode nibble then 12 bit argument
# E hhhh expects one serial word of the frame sent by the last load
C 1D55
C 22AA
C 33C3
C 4FA5
C 5001
C 5000
C 6000
E 00A5
E 0155
E 02AA
E 03C3
C 2123
C F123
C 5FF1
C 6000
E 00A5
E 0155
E 0123
E 03C3
C 5002

// File: microroc_sc.f
+incdir+hdl
hdl/usb_cmd_pkg.sv
hdl/sc_frame_pkg.sv
hdl/usb_cmd_decoder.sv
hdl/sc_word_fifo.sv
hdl/sc_shift_ctrl.sv
hdl/microroc_sc_top.sv
dv/microroc_sc_properties.sv
dv/tb_microroc_sc.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of the slow control testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f microroc_sc.f \
    --top-module tb_microroc_sc -o tb_microroc_sc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_microroc_sc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
